//--- logic/tile_pkg.sv
`default_nettype none

package tile_pkg;

	// ================================================
	// global side
	// ================================================
	// byte address into global memory
	localparam int GBW = 32;
	// one DRAM beat carries a full tile row
	localparam int DBW = 64;

	// ================================================
	// local tile buffer
	// ================================================
	localparam int MAX_ROWS = 16;
	// local row address
	localparam int LBW = $clog2(MAX_ROWS);
	// row count, one bit wider so MAX_ROWS fits
	localparam int RBW = LBW + 1;

	// one queued write command in the collector
	typedef struct packed {
		logic           islast;
		logic [LBW-1:0] local_row;
	} cmd_entry_t;

endpackage

`default_nettype wire

//--- logic/chunk_if.sv
`timescale 1ns/1ps
`default_nettype none

// one tile description, broadcast to both loopers
interface chunk_if;

	logic                       valid;
	// row * pitch + col
	logic [tile_pkg::GBW-1:0]   start_ofs;
	logic [tile_pkg::GBW-1:0]   base;
	logic [tile_pkg::GBW-1:0]   pitch;
	logic [tile_pkg::RBW-1:0]   rows;
	logic [tile_pkg::LBW-1:0]   xor_mask;

	modport src (
		output valid,
		output start_ofs,
		output base,
		output pitch,
		output rows,
		output xor_mask
	);

	modport dst (
		input valid,
		input start_ofs,
		input base,
		input pitch,
		input rows,
		input xor_mask
	);

endinterface

`default_nettype wire

//--- logic/cmd_if.sv
`timescale 1ns/1ps
`default_nettype none

// per-row local write commands
interface cmd_if;

	logic                     valid;
	// row address after swizzle
	logic [tile_pkg::LBW-1:0] local_row;
	logic                     islast;

	modport src (
		output valid,
		output local_row,
		output islast
	);

	modport dst (
		input valid,
		input local_row,
		input islast
	);

endinterface

`default_nettype wire

//--- logic/chunk_head.sv
`timescale 1ns/1ps
`default_nettype none

module chunk_head (
	input  wire logic                     i_clk,
	input  wire logic                     i_rst,
	input  wire logic                     i_req_valid,
	input  wire logic [tile_pkg::GBW-1:0] i_req_base,
	input  wire logic [tile_pkg::GBW-1:0] i_req_pitch,
	input  wire logic [tile_pkg::GBW-1:0] i_req_row,
	input  wire logic [tile_pkg::GBW-1:0] i_req_col,
	input  wire logic [tile_pkg::RBW-1:0] i_req_rows,
	input  wire logic [tile_pkg::LBW-1:0] i_req_xor_mask,
	input  wire logic                     i_tile_done,
	output logic                          o_busy,
	chunk_if.src                          o_chunk
);

	logic accept;

	// one tile at a time, empty or oversized tiles dropped
	assign accept = i_req_valid && !o_busy
		&& (i_req_rows != '0)
		&& (i_req_rows <= tile_pkg::MAX_ROWS);

	// ================================================
	// control
	// ================================================
	always_ff @(posedge i_clk or negedge i_rst) begin
		if (!i_rst) begin
			o_chunk.valid <= 1'b0;
			o_busy        <= 1'b0;
		end else begin
			o_chunk.valid <= accept;
			if (accept) begin
				o_busy <= 1'b1;
			end else if (i_tile_done) begin
				// released the cycle after done
				o_busy <= 1'b0;
			end
		end
	end

	// ================================================
	// tile description
	// ================================================
	always_ff @(posedge i_clk) begin
		if (accept) begin
			// linear offset of the first element
			o_chunk.start_ofs <= i_req_row * i_req_pitch + i_req_col;
			o_chunk.base      <= i_req_base;
			o_chunk.pitch     <= i_req_pitch;
			o_chunk.rows      <= i_req_rows;
			o_chunk.xor_mask  <= i_req_xor_mask;
		end
	end

endmodule

`default_nettype wire

//--- logic/dram_addr_looper.sv
`timescale 1ns/1ps
`default_nettype none

module dram_addr_looper (
	input  wire logic                     i_clk,
	input  wire logic                     i_rst,
	chunk_if.dst                          i_chunk,
	output logic                          o_ra_valid,
	output logic [tile_pkg::GBW-1:0]      o_ra
);

	logic                     active;
	logic [tile_pkg::GBW-1:0] cur_addr;
	logic [tile_pkg::GBW-1:0] pitch;
	// rows still to go after the current one
	logic [tile_pkg::LBW-1:0] rows_left;
	logic [tile_pkg::RBW-1:0] rows_m1;

	assign rows_m1 = i_chunk.rows - 1'b1;

	// ================================================
	// row walk
	// ================================================
	always_ff @(posedge i_clk or negedge i_rst) begin
		if (!i_rst) begin
			active <= 1'b0;
		end else if (i_chunk.valid) begin
			active <= 1'b1;
		end else if (active && (rows_left == '0)) begin
			active <= 1'b0;
		end
	end

	always_ff @(posedge i_clk) begin
		if (i_chunk.valid) begin
			cur_addr  <= i_chunk.base + i_chunk.start_ofs;
			pitch     <= i_chunk.pitch;
			rows_left <= rows_m1[tile_pkg::LBW-1:0];
		end else if (active && (rows_left != '0)) begin
			// next row sits one pitch further
			cur_addr  <= cur_addr + pitch;
			rows_left <= rows_left - 1'b1;
		end
	end

	// one address per cycle, no stalls on the DRAM side
	assign o_ra_valid = active;
	assign o_ra       = cur_addr;

endmodule

`default_nettype wire

//--- logic/sram_cmd_looper.sv
`timescale 1ns/1ps
`default_nettype none

module sram_cmd_looper (
	input  wire logic i_clk,
	input  wire logic i_rst,
	chunk_if.dst      i_chunk,
	cmd_if.src        o_cmd
);

	logic                     active;
	// unswizzled row index
	logic [tile_pkg::LBW-1:0] row_idx;
	logic [tile_pkg::LBW-1:0] last_idx;
	logic [tile_pkg::LBW-1:0] mask;
	logic [tile_pkg::RBW-1:0] rows_m1;
	logic                     at_last;

	assign rows_m1 = i_chunk.rows - 1'b1;
	assign at_last = (row_idx == last_idx);

	// ================================================
	// row counter
	// ================================================
	always_ff @(posedge i_clk or negedge i_rst) begin
		if (!i_rst) begin
			active <= 1'b0;
		end else if (i_chunk.valid) begin
			active <= 1'b1;
		end else if (active && at_last) begin
			active <= 1'b0;
		end
	end

	always_ff @(posedge i_clk) begin
		if (i_chunk.valid) begin
			row_idx  <= '0;
			last_idx <= rows_m1[tile_pkg::LBW-1:0];
			mask     <= i_chunk.xor_mask;
		end else if (active && !at_last) begin
			row_idx <= row_idx + 1'b1;
		end
	end

	// ================================================
	// command out
	// ================================================
	// xor swizzle spreads rows across the buffer
	assign o_cmd.valid     = active;
	assign o_cmd.local_row = row_idx ^ mask;
	assign o_cmd.islast    = at_last;

endmodule

`default_nettype wire

//--- logic/sram_write_collector.sv
`timescale 1ns/1ps
`default_nettype none

module sram_write_collector #(
	parameter int QUEUE_DEPTH = 16
) (
	input  wire logic                     i_clk,
	input  wire logic                     i_rst,
	cmd_if.dst                            i_cmd,
	input  wire logic                     i_rd_valid,
	input  wire logic [tile_pkg::DBW-1:0] i_rd_data,
	input  wire logic                     i_sram_re,
	input  wire logic [tile_pkg::LBW-1:0] i_sram_raddr,
	output logic                          o_sram_rvalid,
	output logic [tile_pkg::DBW-1:0]      o_sram_rdata,
	output logic                          o_tile_done
);

	localparam int PTR_BW = $clog2(QUEUE_DEPTH);
	localparam int CNT_BW = $clog2(QUEUE_DEPTH + 1);

	tile_pkg::cmd_entry_t     queue [QUEUE_DEPTH];
	logic [PTR_BW-1:0]        wr_ptr;
	logic [PTR_BW-1:0]        rd_ptr;
	logic [CNT_BW-1:0]        q_count;
	logic                     q_empty;
	logic                     bypass;
	logic                     push;
	logic                     pop;
	tile_pkg::cmd_entry_t     head;
	logic [tile_pkg::DBW-1:0] tile_mem [tile_pkg::MAX_ROWS];

	// ================================================
	// command queue
	// ================================================
	assign q_empty = (q_count == '0);
	// beat and its command in the same cycle skips the queue
	assign bypass  = i_rd_valid && q_empty;
	assign push    = i_cmd.valid && !bypass;
	assign pop     = i_rd_valid && !q_empty;

	always_comb begin
		if (q_empty) begin
			head.islast    = i_cmd.islast;
			head.local_row = i_cmd.local_row;
		end else begin
			head = queue[rd_ptr];
		end
	end

	always_ff @(posedge i_clk or negedge i_rst) begin
		if (!i_rst) begin
			wr_ptr  <= '0;
			rd_ptr  <= '0;
			q_count <= '0;
		end else begin
			if (push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			case ({push, pop})
				2'b10: q_count <= q_count + 1'b1;
				2'b01: q_count <= q_count - 1'b1;
				default: q_count <= q_count;
			endcase
		end
	end

	always_ff @(posedge i_clk) begin
		if (push) begin
			queue[wr_ptr].islast    <= i_cmd.islast;
			queue[wr_ptr].local_row <= i_cmd.local_row;
		end
	end

	// ================================================
	// tile buffer
	// ================================================
	always_ff @(posedge i_clk) begin
		if (i_rd_valid) begin
			tile_mem[head.local_row] <= i_rd_data;
		end
		if (i_sram_re) begin
			o_sram_rdata <= tile_mem[i_sram_raddr];
		end
	end

	// read strobe and done pulse
	always_ff @(posedge i_clk or negedge i_rst) begin
		if (!i_rst) begin
			o_sram_rvalid <= 1'b0;
			o_tile_done   <= 1'b0;
		end else begin
			o_sram_rvalid <= i_sram_re;
			// last row landed on the previous edge
			o_tile_done   <= i_rd_valid && head.islast;
		end
	end

endmodule

`default_nettype wire

//--- logic/tile_read_pipeline.sv
`timescale 1ns/1ps
`default_nettype none

module tile_read_pipeline #(
	parameter int QUEUE_DEPTH = 16
) (
	input  wire logic                     i_clk,
	input  wire logic                     i_rst,
	// tile request
	input  wire logic                     i_req_valid,
	input  wire logic [tile_pkg::GBW-1:0] i_req_base,
	input  wire logic [tile_pkg::GBW-1:0] i_req_pitch,
	input  wire logic [tile_pkg::GBW-1:0] i_req_row,
	input  wire logic [tile_pkg::GBW-1:0] i_req_col,
	input  wire logic [tile_pkg::RBW-1:0] i_req_rows,
	input  wire logic [tile_pkg::LBW-1:0] i_req_xor_mask,
	output logic                          o_busy,
	// DRAM
	output logic                          o_dram_ra_valid,
	output logic [tile_pkg::GBW-1:0]      o_dram_ra,
	input  wire logic                     i_dram_rd_valid,
	input  wire logic [tile_pkg::DBW-1:0] i_dram_rd_data,
	// local buffer read port
	input  wire logic                     i_sram_re,
	input  wire logic [tile_pkg::LBW-1:0] i_sram_raddr,
	output logic                          o_sram_rvalid,
	output logic [tile_pkg::DBW-1:0]      o_sram_rdata,
	output logic                          o_tile_done
);

	chunk_if u_chunk ();
	cmd_if   u_cmd ();

	// ================================================
	// request front
	// ================================================
	chunk_head u_chunk_head (
		.i_clk          (i_clk),
		.i_rst          (i_rst),
		.i_req_valid    (i_req_valid),
		.i_req_base     (i_req_base),
		.i_req_pitch    (i_req_pitch),
		.i_req_row      (i_req_row),
		.i_req_col      (i_req_col),
		.i_req_rows     (i_req_rows),
		.i_req_xor_mask (i_req_xor_mask),
		.i_tile_done    (o_tile_done),
		.o_busy         (o_busy),
		.o_chunk        (u_chunk.src)
	);

	// ================================================
	// loopers, side by side
	// ================================================
	dram_addr_looper u_dram_addr_looper (
		.i_clk      (i_clk),
		.i_rst      (i_rst),
		.i_chunk    (u_chunk.dst),
		.o_ra_valid (o_dram_ra_valid),
		.o_ra       (o_dram_ra)
	);

	sram_cmd_looper u_sram_cmd_looper (
		.i_clk   (i_clk),
		.i_rst   (i_rst),
		.i_chunk (u_chunk.dst),
		.o_cmd   (u_cmd.src)
	);

	// data return into the tile buffer
	sram_write_collector #(
		.QUEUE_DEPTH (QUEUE_DEPTH)
	) u_sram_write_collector (
		.i_clk         (i_clk),
		.i_rst         (i_rst),
		.i_cmd         (u_cmd.dst),
		.i_rd_valid    (i_dram_rd_valid),
		.i_rd_data     (i_dram_rd_data),
		.i_sram_re     (i_sram_re),
		.i_sram_raddr  (i_sram_raddr),
		.o_sram_rvalid (o_sram_rvalid),
		.o_sram_rdata  (o_sram_rdata),
		.o_tile_done   (o_tile_done)
	);

endmodule

`default_nettype wire

//--- bench/tile_read_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module tile_read_assertions (
	input wire logic i_clk,
	input wire logic i_rst,
	input wire logic i_busy,
	input wire logic i_dram_ra_valid,
	input wire logic i_tile_done,
	input wire logic i_sram_re,
	input wire logic i_sram_rvalid
);

	int fail_count = 0;

	// done is a single pulse per tile
	a_done_pulse: assert property (@(posedge i_clk) disable iff (!i_rst)
		i_tile_done |=> !i_tile_done)
		else begin fail_count++; $error("tile done high two cycles running"); end

	// registered read port
	a_rvalid_on: assert property (@(posedge i_clk) disable iff (!i_rst)
		i_sram_re |=> i_sram_rvalid)
		else begin fail_count++; $error("read valid missing after read strobe"); end

	a_rvalid_off: assert property (@(posedge i_clk) disable iff (!i_rst)
		!i_sram_re |=> !i_sram_rvalid)
		else begin fail_count++; $error("read valid without read strobe"); end

	a_ra_idle: assert property (@(posedge i_clk) disable iff (!i_rst)
		i_dram_ra_valid |-> i_busy)
		else begin fail_count++; $error("address strobe while idle"); end

	// strobes held low in reset
	a_reset_quiet: assert property (@(posedge i_clk)
		!i_rst |-> (!i_dram_ra_valid && !i_tile_done && !i_sram_rvalid && !i_busy))
		else begin fail_count++; $error("strobe active during reset"); end

endmodule

bind tile_read_pipeline tile_read_assertions u_tile_read_assertions (
	.i_clk           (i_clk),
	.i_rst           (i_rst),
	.i_busy          (o_busy),
	.i_dram_ra_valid (o_dram_ra_valid),
	.i_tile_done     (o_tile_done),
	.i_sram_re       (i_sram_re),
	.i_sram_rvalid   (o_sram_rvalid)
);

`default_nettype wire

//--- bench/tb_tile_read_pipeline.sv
`timescale 1ns/1ps
`default_nettype none

module tb_tile_read_pipeline;

	logic                     i_clk;
	logic                     i_rst;
	logic                     i_req_valid;
	logic [tile_pkg::GBW-1:0] i_req_base;
	logic [tile_pkg::GBW-1:0] i_req_pitch;
	logic [tile_pkg::GBW-1:0] i_req_row;
	logic [tile_pkg::GBW-1:0] i_req_col;
	logic [tile_pkg::RBW-1:0] i_req_rows;
	logic [tile_pkg::LBW-1:0] i_req_xor_mask;
	logic                     i_dram_rd_valid;
	logic [tile_pkg::DBW-1:0] i_dram_rd_data;
	logic                     i_sram_re;
	logic [tile_pkg::LBW-1:0] i_sram_raddr;
	logic                     o_busy;
	logic                     o_dram_ra_valid;
	logic [tile_pkg::GBW-1:0] o_dram_ra;
	logic                     o_sram_rvalid;
	logic [tile_pkg::DBW-1:0] o_sram_rdata;
	logic                     o_tile_done;

	// reference model state
	int          cyc = 0;
	int          acc_cyc = 0;
	int          k_now;
	bit          have_req = 1'b0;
	bit          req_ok = 1'b0;
	logic [31:0] m_base = '0;
	logic [31:0] m_pitch = '0;
	logic [31:0] m_row = '0;
	logic [31:0] m_col = '0;
	int          m_rows = 0;
	int          beats_left = 0;
	logic        exp_done = 1'b0;
	logic        exp_ra_valid;
	logic [31:0] exp_ra;
	logic [63:0] exp_rdata = '0;
	logic [63:0] rd_exp_q = '0;
	logic [31:0] dq_addr [$];
	int          dq_due [$];
	int          last_due = 0;
	string       test_name = "reset";
	int          errors = 0;
	int          err_mark = 0;
	int          tests = 0;
	int          failed = 0;
	int          total;
	logic [3:0]  masks [4] = '{4'h0, 4'hf, 4'h9, 4'h6};

	tile_read_pipeline #(
		.QUEUE_DEPTH (16)
	) u_tile_read_pipeline (.*);

	initial begin
		i_clk = 1'b0;
		forever #10 i_clk = ~i_clk;
	end

	function automatic logic [31:0] row_addr(input logic [31:0] b, input logic [31:0] p,
		input logic [31:0] r, input logic [31:0] c, input int k);
		return b + (r + k) * p + c;
	endfunction

	// DRAM beat derived from its address
	function automatic logic [63:0] fold_beat(input logic [31:0] a);
		return {a ^ 32'hc3a5_5a3c, a};
	endfunction

	function automatic int total_errors();
		return errors + u_tile_read_pipeline.u_tile_read_assertions.fail_count;
	endfunction

	function automatic void report_mismatch(input string what, input logic [63:0] exp_v,
		input logic [63:0] act_v);
		errors++;
		$display("ERROR %s %s: expected %h actual %h", test_name, what, exp_v, act_v);
	endfunction

	// ==================================================
	// expected behavior
	// ==================================================
	// row k of the tile strobes k+2 cycles after the accepted request
	assign k_now        = cyc - acc_cyc - 2;
	assign exp_ra_valid = have_req && (k_now >= 0) && (k_now < m_rows);
	assign exp_ra       = row_addr(m_base, m_pitch, m_row, m_col, k_now);

	always @(posedge i_clk) begin
		cyc      <= cyc + 1;
		rd_exp_q <= exp_rdata;
		exp_done <= i_dram_rd_valid && (beats_left == 1);
		if (i_req_valid && req_ok) begin
			have_req   <= 1'b1;
			acc_cyc    <= cyc;
			m_base     <= i_req_base;
			m_pitch    <= i_req_pitch;
			m_row      <= i_req_row;
			m_col      <= i_req_col;
			m_rows     <= i_req_rows;
			beats_left <= i_req_rows;
		end else if (i_dram_rd_valid) begin
			beats_left <= beats_left - 1;
		end
	end

	a_ra_valid: assert property (@(posedge i_clk) disable iff (!i_rst)
		o_dram_ra_valid == exp_ra_valid)
		else report_mismatch("address strobe", $sampled(exp_ra_valid), $sampled(o_dram_ra_valid));
	a_ra: assert property (@(posedge i_clk) disable iff (!i_rst)
		o_dram_ra_valid |-> (o_dram_ra == exp_ra))
		else report_mismatch("address", $sampled(exp_ra), $sampled(o_dram_ra));
	a_done: assert property (@(posedge i_clk) disable iff (!i_rst)
		o_tile_done == exp_done)
		else report_mismatch("tile done", $sampled(exp_done), $sampled(o_tile_done));
	a_busy_drop: assert property (@(posedge i_clk) disable iff (!i_rst)
		o_tile_done |=> !o_busy)
		else begin
			errors++;
			$display("%s: busy did not fall after tile done", test_name);
		end
	a_rdata: assert property (@(posedge i_clk) disable iff (!i_rst)
		i_sram_re |=> (o_sram_rvalid && (o_sram_rdata == rd_exp_q)))
		else report_mismatch("read data", $sampled(rd_exp_q), $sampled(o_sram_rdata));

	// ==================================================
	// in-order DRAM model with 1 to 4 cycles of latency
	// ==================================================
	always @(negedge i_clk) begin : dram_model
		int due;
		i_dram_rd_valid = 1'b0;
		if ((dq_addr.size() > 0) && (dq_due[0] <= cyc)) begin
			i_dram_rd_valid = 1'b1;
			i_dram_rd_data  = fold_beat(dq_addr.pop_front());
			void'(dq_due.pop_front());
		end
		if (o_dram_ra_valid) begin
			due = cyc + $urandom_range(4, 1);
			if (due <= last_due) due = last_due + 1;
			last_due = due;
			dq_addr.push_back(o_dram_ra);
			dq_due.push_back(due);
		end
	end

	task automatic fail_timeout(input string what);
		$display("%s: timed out waiting for %s", test_name, what);
		$display("FAIL: see errors above");
		$finish;
	endtask

	task automatic wait_idle();
		int n;
		n = 0;
		while (o_busy) begin
			@(negedge i_clk);
			n++;
			if (n > 100) fail_timeout("idle");
		end
	endtask

	task automatic wait_done();
		int n;
		n = 0;
		while (!o_tile_done) begin
			@(negedge i_clk);
			n++;
			if (n > 200) fail_timeout("tile done");
		end
	endtask

	// one tile with an optional second request while busy and a read back
	task automatic run_tile(input logic [31:0] base, input logic [31:0] pitch,
		input logic [31:0] row, input logic [31:0] col, input int rows,
		input logic [3:0] mask, input bit poke);
		wait_idle();
		i_req_valid    = 1'b1;
		req_ok         = 1'b1;
		i_req_base     = base;
		i_req_pitch    = pitch;
		i_req_row      = row;
		i_req_col      = col;
		i_req_rows     = tile_pkg::RBW'(rows);
		i_req_xor_mask = mask;
		@(negedge i_clk);
		i_req_valid = poke;
		i_req_base  = base + 32'h0001_0000;
		req_ok      = 1'b0;
		@(negedge i_clk);
		i_req_valid = 1'b0;
		wait_done();
		for (int r = 0; r < rows; r++) begin
			i_sram_re    = 1'b1;
			i_sram_raddr = tile_pkg::LBW'(r) ^ mask;
			exp_rdata    = fold_beat(row_addr(base, pitch, row, col, r));
			@(negedge i_clk);
		end
		i_sram_re = 1'b0;
		// last read data returns on the next edge
		@(negedge i_clk);
	endtask

	task automatic begin_test(input string name);
		test_name = name;
		err_mark  = total_errors();
	endtask

	task automatic end_test();
		tests++;
		if (total_errors() != err_mark) begin
			failed++;
			$display("%s: failed", test_name);
		end else begin
			$display("%s: ok", test_name);
		end
	endtask

	// ==================================================
	// stimulus
	// ==================================================
	initial begin
		void'($urandom(32'h84cda24c));
		i_rst          = 1'b1;
		i_req_valid    = 1'b0;
		i_req_base     = '0;
		i_req_pitch    = '0;
		i_req_row      = '0;
		i_req_col      = '0;
		i_req_rows     = '0;
		i_req_xor_mask = '0;
		i_dram_rd_valid = 1'b0;
		i_dram_rd_data = '0;
		i_sram_re      = 1'b0;
		i_sram_raddr   = '0;
		#1;
		i_rst = 1'b0;
		repeat (5) @(negedge i_clk);
		i_rst = 1'b1;
		@(negedge i_clk);

		begin_test("basic");
		run_tile(32'h1000_0000, 32'h100, 32'd3, 32'd8, 4, 4'h0, 1'b0);
		end_test();
		begin_test("swizzle");
		run_tile(32'h2000_0040, 32'h80, 32'd1, 32'd4, 8, 4'h5, 1'b0);
		end_test();
		begin_test("busy_ignore");
		run_tile(32'h3000_0000, 32'h200, 32'd2, 32'd0, 6, 4'h3, 1'b1);
		end_test();

		begin_test("zero_rows");
		wait_idle();
		i_req_valid = 1'b1;
		i_req_rows  = '0;
		@(negedge i_clk);
		i_req_valid = 1'b0;
		repeat (6) @(negedge i_clk);
		end_test();

		begin_test("full_height");
		foreach (masks[i]) begin
			run_tile($urandom, $urandom_range(512, 8), $urandom_range(31, 0),
				$urandom_range(63, 0), 16, masks[i], 1'b0);
		end
		end_test();

		begin_test("random");
		repeat (10) begin
			run_tile($urandom, $urandom_range(1024, 1), $urandom_range(63, 0),
				$urandom_range(255, 0), $urandom_range(16, 1), $urandom_range(15, 0),
				$urandom_range(1, 0));
		end
		end_test();

		total = total_errors();
		$display("tests %0d, failed %0d, errors %0d", tests, failed, total);
		if (total == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- files.f
logic/tile_pkg.sv
logic/chunk_if.sv
logic/cmd_if.sv
logic/chunk_head.sv
logic/dram_addr_looper.sv
logic/sram_cmd_looper.sv
logic/sram_write_collector.sv
logic/tile_read_pipeline.sv
bench/tile_read_assertions.sv
bench/tb_tile_read_pipeline.sv
